/* hw/core_mem_pkg.sv */
package core_mem_pkg;

    parameter int XLEN          = 32;
    parameter int REG_BITS      = 5;
    parameter int CSR_ADDR_BITS = 12;
    parameter int LANES         = 4;
    parameter int LANE_BITS     = $clog2(LANES);

    // machine CSR addresses
    parameter logic [CSR_ADDR_BITS-1:0] CSR_MSCRATCH = 12'h340;
    parameter logic [CSR_ADDR_BITS-1:0] CSR_MTVEC    = 12'h305;
    parameter logic [CSR_ADDR_BITS-1:0] CSR_MEPC     = 12'h341;
    parameter logic [CSR_ADDR_BITS-1:0] CSR_MCAUSE   = 12'h342;

    // one data word seen whole or by byte lane
    typedef union packed {
        logic [XLEN-1:0]        word;
        logic [LANES-1:0][7:0]  bytes;
    } mem_word_u;

    // lowest lane set in a strobe
    function automatic logic [LANE_BITS-1:0] low_lane(input logic [LANES-1:0] strb);
        logic [LANE_BITS-1:0] lane;
        lane = LANE_BITS'(LANES - 1);
        for (int i = LANES - 1; i >= 0; i--) begin
            if (strb[i]) begin
                lane = LANE_BITS'(i);
            end
        end
        return lane;
    endfunction

endpackage

/* hw/cushion.sv */
`timescale 1ns/1ps

module cushion import core_mem_pkg::*; (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     mem_wait,

    // from execute
    input  logic [REG_BITS-1:0]      exec_reg_w_rd,
    input  logic [XLEN-1:0]          exec_reg_w_data,
    input  logic                     exec_csr_w_valid,
    input  logic [CSR_ADDR_BITS-1:0] exec_csr_w_addr,
    input  logic [XLEN-1:0]          exec_csr_w_data,
    input  logic                     exec_mem_r_valid,
    input  logic [REG_BITS-1:0]      exec_mem_r_rd,
    input  logic [XLEN-1:0]          exec_mem_r_addr,
    input  logic [LANES-1:0]         exec_mem_r_strb,
    input  logic                     exec_mem_r_signed,
    input  logic                     exec_mem_w_valid,
    input  logic [XLEN-1:0]          exec_mem_w_addr,
    input  logic [LANES-1:0]         exec_mem_w_strb,
    input  logic [XLEN-1:0]          exec_mem_w_data,
    input  logic                     exec_jmp_do,
    input  logic [XLEN-1:0]          exec_jmp_pc,

    // to memory access
    output logic [REG_BITS-1:0]      cushion_reg_w_rd,
    output logic [XLEN-1:0]          cushion_reg_w_data,
    output logic                     cushion_csr_w_valid,
    output logic [CSR_ADDR_BITS-1:0] cushion_csr_w_addr,
    output logic [XLEN-1:0]          cushion_csr_w_data,
    output logic                     cushion_mem_r_valid,
    output logic [REG_BITS-1:0]      cushion_mem_r_rd,
    output logic [XLEN-1:0]          cushion_mem_r_addr,
    output logic [LANES-1:0]         cushion_mem_r_strb,
    output logic                     cushion_mem_r_signed,
    output logic                     cushion_mem_w_valid,
    output logic [XLEN-1:0]          cushion_mem_w_addr,
    output logic [LANES-1:0]         cushion_mem_w_strb,
    output logic [XLEN-1:0]          cushion_mem_w_data,
    output logic                     cushion_jmp_do,
    output logic [XLEN-1:0]          cushion_jmp_pc
);

    // flush wins over a stall
    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            cushion_reg_w_rd     <= '0;
            cushion_reg_w_data   <= '0;
            cushion_csr_w_valid  <= 1'b0;
            cushion_csr_w_addr   <= '0;
            cushion_csr_w_data   <= '0;
            cushion_mem_r_valid  <= 1'b0;
            cushion_mem_r_rd     <= '0;
            cushion_mem_r_addr   <= '0;
            cushion_mem_r_strb   <= '0;
            cushion_mem_r_signed <= 1'b0;
            cushion_mem_w_valid  <= 1'b0;
            cushion_mem_w_addr   <= '0;
            cushion_mem_w_strb   <= '0;
            cushion_mem_w_data   <= '0;
            cushion_jmp_do       <= 1'b0;
            cushion_jmp_pc       <= '0;
        end else if (!mem_wait) begin
            cushion_reg_w_rd     <= exec_reg_w_rd;
            cushion_reg_w_data   <= exec_reg_w_data;
            cushion_csr_w_valid  <= exec_csr_w_valid;
            cushion_csr_w_addr   <= exec_csr_w_addr;
            cushion_csr_w_data   <= exec_csr_w_data;
            cushion_mem_r_valid  <= exec_mem_r_valid;
            cushion_mem_r_rd     <= exec_mem_r_rd;
            cushion_mem_r_addr   <= exec_mem_r_addr;
            cushion_mem_r_strb   <= exec_mem_r_strb;
            cushion_mem_r_signed <= exec_mem_r_signed;
            cushion_mem_w_valid  <= exec_mem_w_valid;
            cushion_mem_w_addr   <= exec_mem_w_addr;
            cushion_mem_w_strb   <= exec_mem_w_strb;
            cushion_mem_w_data   <= exec_mem_w_data;
            cushion_jmp_do       <= exec_jmp_do;
            cushion_jmp_pc       <= exec_jmp_pc;
        end
    end

endmodule

/* hw/store_align.sv */
`timescale 1ns/1ps

module store_align import core_mem_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                         CLK,
    input  logic                         reset,
    input  logic                         mem_wait,
    input  logic                         mem_r_valid,
    input  logic [REG_BITS-1:0]          mem_r_rd,
    input  logic [XLEN-1:0]              mem_r_addr,
    input  logic [LANES-1:0]             mem_r_strb,
    input  logic                         mem_r_signed,
    input  logic                         mem_w_valid,
    input  logic [XLEN-1:0]              mem_w_addr,
    input  logic [LANES-1:0]             mem_w_strb,
    input  logic [XLEN-1:0]              mem_w_data,
    output logic [$clog2(DEPTH_WORDS)-1:0] word_idx,
    output logic [LANES-1:0]             lane_we,
    output logic [LANES-1:0][7:0]        lane_wdata,
    output logic                         lane_re,
    output logic                         ld_fire,
    output logic [REG_BITS-1:0]          ld_rd,
    output logic [LANES-1:0]             ld_strb,
    output logic                         ld_signed
);

    localparam int IDX_BITS = $clog2(DEPTH_WORDS);

    logic       rd_go;
    mem_word_u  st_word;

    // store wins the row index
    assign word_idx = mem_w_valid ? mem_w_addr[IDX_BITS+1:2] : mem_r_addr[IDX_BITS+1:2];
    assign rd_go    = mem_r_valid & ~mem_w_valid;
    assign lane_re  = rd_go & ~mem_wait;
    assign lane_we  = mem_w_strb & {LANES{mem_w_valid & ~mem_wait}};

    // low-aligned store value moved up to its first strobed lane
    assign st_word.word = mem_w_data << {low_lane(mem_w_strb), 3'b000};
    assign lane_wdata   = st_word.bytes;

    always_ff @(posedge CLK) begin
        if (reset) begin
            ld_fire <= 1'b0;
        end else if (!mem_wait) begin
            ld_fire <= rd_go;
        end
    end

    // tag lines up with bank read data
    always_ff @(posedge CLK) begin
        if (lane_re) begin
            ld_rd     <= mem_r_rd;
            ld_strb   <= mem_r_strb;
            ld_signed <= mem_r_signed;
        end
    end

endmodule

/* hw/data_bank.sv */
`timescale 1ns/1ps

module data_bank #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                           CLK,
    input  logic                           we,
    input  logic                           re,
    input  logic [$clog2(DEPTH_WORDS)-1:0] idx,
    input  logic [7:0]                     wdata,
    output logic [7:0]                     rdata
);

    logic [7:0] mem [DEPTH_WORDS];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    // registered read held while re is low
    always_ff @(posedge CLK) begin
        if (re) begin
            rdata <= mem[idx];
        end
    end

endmodule

/* hw/load_align.sv */
`timescale 1ns/1ps

module load_align import core_mem_pkg::*; (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  mem_wait,
    input  logic                  ld_fire,
    input  logic [REG_BITS-1:0]   ld_rd,
    input  logic [LANES-1:0]      ld_strb,
    input  logic                  ld_signed,
    input  logic [LANES-1:0][7:0] lane_rdata,
    output logic                  load_w_valid,
    output logic [REG_BITS-1:0]   load_w_rd,
    output logic [XLEN-1:0]       load_w_data
);

    mem_word_u       rd_word;
    mem_word_u       shifted;
    logic [XLEN-1:0] ext;
    logic            take;

    assign rd_word.bytes = lane_rdata;
    assign shifted.word  = rd_word.word >> {low_lane(ld_strb), 3'b000};
    assign take          = ld_fire & ~mem_wait;

    // size from the strobe, sign from the top loaded byte
    always_comb begin
        case (ld_strb)
            4'b1111: begin
                ext = shifted.word;
            end
            4'b0011, 4'b1100: begin
                ext = {{16{ld_signed & shifted.bytes[1][7]}}, shifted.bytes[1], shifted.bytes[0]};
            end
            default: begin
                ext = {{24{ld_signed & shifted.bytes[0][7]}}, shifted.bytes[0]};
            end
        endcase
    end

    // one pulse per fired load
    always_ff @(posedge CLK) begin
        if (reset) begin
            load_w_valid <= 1'b0;
        end else begin
            load_w_valid <= take;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            load_w_rd   <= ld_rd;
            load_w_data <= ext;
        end
    end

endmodule

/* hw/csr_file.sv */
`timescale 1ns/1ps

module csr_file import core_mem_pkg::*; (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     w_valid,
    input  logic [CSR_ADDR_BITS-1:0] w_addr,
    input  logic [XLEN-1:0]          w_data,
    input  logic [CSR_ADDR_BITS-1:0] r_addr,
    output logic [XLEN-1:0]          r_data
);

    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;

    always_ff @(posedge CLK) begin
        if (reset) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (w_valid) begin
            case (w_addr)
                CSR_MSCRATCH: mscratch <= w_data;
                CSR_MTVEC:    mtvec    <= w_data;
                CSR_MEPC:     mepc     <= w_data;
                CSR_MCAUSE:   mcause   <= w_data;
                // unknown address is dropped
                default: ;
            endcase
        end
    end

    always_comb begin
        case (r_addr)
            CSR_MSCRATCH: r_data = mscratch;
            CSR_MTVEC:    r_data = mtvec;
            CSR_MEPC:     r_data = mepc;
            CSR_MCAUSE:   r_data = mcause;
            default:      r_data = '0;
        endcase
    end

endmodule

/* hw/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top import core_mem_pkg::*; #(
    parameter int DEPTH_WORDS = 256
) (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     mem_wait,
    input  logic [REG_BITS-1:0]      exec_reg_w_rd,
    input  logic [XLEN-1:0]          exec_reg_w_data,
    input  logic                     exec_csr_w_valid,
    input  logic [CSR_ADDR_BITS-1:0] exec_csr_w_addr,
    input  logic [XLEN-1:0]          exec_csr_w_data,
    input  logic                     exec_mem_r_valid,
    input  logic [REG_BITS-1:0]      exec_mem_r_rd,
    input  logic [XLEN-1:0]          exec_mem_r_addr,
    input  logic [LANES-1:0]         exec_mem_r_strb,
    input  logic                     exec_mem_r_signed,
    input  logic                     exec_mem_w_valid,
    input  logic [XLEN-1:0]          exec_mem_w_addr,
    input  logic [LANES-1:0]         exec_mem_w_strb,
    input  logic [XLEN-1:0]          exec_mem_w_data,
    input  logic                     exec_jmp_do,
    input  logic [XLEN-1:0]          exec_jmp_pc,
    input  logic [CSR_ADDR_BITS-1:0] csr_r_addr,
    output logic [REG_BITS-1:0]      reg_w_rd,
    output logic [XLEN-1:0]          reg_w_data,
    output logic                     jmp_do,
    output logic [XLEN-1:0]          jmp_pc,
    output logic                     load_w_valid,
    output logic [REG_BITS-1:0]      load_w_rd,
    output logic [XLEN-1:0]          load_w_data,
    output logic [XLEN-1:0]          csr_r_data
);

    localparam int IDX_BITS = $clog2(DEPTH_WORDS);

    logic                     cushion_csr_w_valid;
    logic [CSR_ADDR_BITS-1:0] cushion_csr_w_addr;
    logic [XLEN-1:0]          cushion_csr_w_data;
    logic                     cushion_mem_r_valid;
    logic [REG_BITS-1:0]      cushion_mem_r_rd;
    logic [XLEN-1:0]          cushion_mem_r_addr;
    logic [LANES-1:0]         cushion_mem_r_strb;
    logic                     cushion_mem_r_signed;
    logic                     cushion_mem_w_valid;
    logic [XLEN-1:0]          cushion_mem_w_addr;
    logic [LANES-1:0]         cushion_mem_w_strb;
    logic [XLEN-1:0]          cushion_mem_w_data;

    logic [IDX_BITS-1:0]      word_idx;
    logic [LANES-1:0]         lane_we;
    logic [LANES-1:0][7:0]    lane_wdata;
    logic [LANES-1:0][7:0]    lane_rdata;
    logic                     lane_re;
    logic                     ld_fire;
    logic [REG_BITS-1:0]      ld_rd;
    logic [LANES-1:0]         ld_strb;
    logic                     ld_signed;

    // register write and jump leave straight from the stage register
    cushion u_cushion (
        .CLK(CLK), .reset(reset), .flush(flush), .mem_wait(mem_wait),
        .exec_reg_w_rd(exec_reg_w_rd), .exec_reg_w_data(exec_reg_w_data),
        .exec_csr_w_valid(exec_csr_w_valid), .exec_csr_w_addr(exec_csr_w_addr),
        .exec_csr_w_data(exec_csr_w_data),
        .exec_mem_r_valid(exec_mem_r_valid), .exec_mem_r_rd(exec_mem_r_rd),
        .exec_mem_r_addr(exec_mem_r_addr), .exec_mem_r_strb(exec_mem_r_strb),
        .exec_mem_r_signed(exec_mem_r_signed),
        .exec_mem_w_valid(exec_mem_w_valid), .exec_mem_w_addr(exec_mem_w_addr),
        .exec_mem_w_strb(exec_mem_w_strb), .exec_mem_w_data(exec_mem_w_data),
        .exec_jmp_do(exec_jmp_do), .exec_jmp_pc(exec_jmp_pc),
        .cushion_reg_w_rd(reg_w_rd), .cushion_reg_w_data(reg_w_data),
        .cushion_csr_w_valid(cushion_csr_w_valid), .cushion_csr_w_addr(cushion_csr_w_addr),
        .cushion_csr_w_data(cushion_csr_w_data),
        .cushion_mem_r_valid(cushion_mem_r_valid), .cushion_mem_r_rd(cushion_mem_r_rd),
        .cushion_mem_r_addr(cushion_mem_r_addr), .cushion_mem_r_strb(cushion_mem_r_strb),
        .cushion_mem_r_signed(cushion_mem_r_signed),
        .cushion_mem_w_valid(cushion_mem_w_valid), .cushion_mem_w_addr(cushion_mem_w_addr),
        .cushion_mem_w_strb(cushion_mem_w_strb), .cushion_mem_w_data(cushion_mem_w_data),
        .cushion_jmp_do(jmp_do), .cushion_jmp_pc(jmp_pc)
    );

    store_align #(.DEPTH_WORDS(DEPTH_WORDS)) u_store_align (
        .CLK(CLK), .reset(reset), .mem_wait(mem_wait),
        .mem_r_valid(cushion_mem_r_valid), .mem_r_rd(cushion_mem_r_rd),
        .mem_r_addr(cushion_mem_r_addr), .mem_r_strb(cushion_mem_r_strb),
        .mem_r_signed(cushion_mem_r_signed),
        .mem_w_valid(cushion_mem_w_valid), .mem_w_addr(cushion_mem_w_addr),
        .mem_w_strb(cushion_mem_w_strb), .mem_w_data(cushion_mem_w_data),
        .word_idx(word_idx), .lane_we(lane_we), .lane_wdata(lane_wdata),
        .lane_re(lane_re), .ld_fire(ld_fire), .ld_rd(ld_rd),
        .ld_strb(ld_strb), .ld_signed(ld_signed)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        data_bank #(.DEPTH_WORDS(DEPTH_WORDS)) u_bank (
            .CLK(CLK), .we(lane_we[i]), .re(lane_re), .idx(word_idx),
            .wdata(lane_wdata[i]), .rdata(lane_rdata[i])
        );
    end

    load_align u_load_align (
        .CLK(CLK), .reset(reset), .mem_wait(mem_wait),
        .ld_fire(ld_fire), .ld_rd(ld_rd), .ld_strb(ld_strb), .ld_signed(ld_signed),
        .lane_rdata(lane_rdata),
        .load_w_valid(load_w_valid), .load_w_rd(load_w_rd), .load_w_data(load_w_data)
    );

    csr_file u_csr_file (
        .CLK(CLK), .reset(reset),
        .w_valid(cushion_csr_w_valid), .w_addr(cushion_csr_w_addr),
        .w_data(cushion_csr_w_data),
        .r_addr(csr_r_addr), .r_data(csr_r_data)
    );

endmodule

/* tests/mem_stage_asserts.sv */
`timescale 1ns/1ps

module mem_stage_asserts (
    input logic       CLK,
    input logic       reset,
    input logic       flush,
    input logic       mem_wait,
    input logic       load_w_valid,
    input logic       jmp_do,
    input logic       csr_w_valid,
    input logic       mem_r_valid,
    input logic       mem_w_valid,
    input logic       lane_re,
    input logic [3:0] lane_we
);

    int fail_count = 0;

    // two pulses in a row need two separate bank reads
    wb_pulse: assert property (@(posedge CLK) disable iff (reset)
        (load_w_valid && $past(load_w_valid)) |-> $past(lane_re, 2))
        else begin
            fail_count++;
            $error("load_w_valid repeated without a new bank read");
        end

    stage_cleared: assert property (@(posedge CLK)
        (reset || flush) |=> !(csr_w_valid || mem_r_valid || mem_w_valid || jmp_do))
        else begin
            fail_count++;
            $error("stage valid high in the cycle after reset or flush");
        end

    no_write_stalled: assert property (@(posedge CLK) disable iff (reset)
        mem_wait |-> (lane_we == 4'b0000))
        else begin
            fail_count++;
            $error("bank write enabled while mem_wait is high");
        end

endmodule

bind mem_stage_top mem_stage_asserts asserts_inst (
    .CLK(CLK), .reset(reset), .flush(flush), .mem_wait(mem_wait),
    .load_w_valid(load_w_valid), .jmp_do(jmp_do),
    .csr_w_valid(cushion_csr_w_valid), .mem_r_valid(cushion_mem_r_valid),
    .mem_w_valid(cushion_mem_w_valid), .lane_re(lane_re), .lane_we(lane_we)
);

/* tests/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb import core_mem_pkg::*; ();

    localparam int DEPTH_WORDS = 256;
    localparam int IDX_BITS    = $clog2(DEPTH_WORDS);
    localparam int CLK_PERIOD  = 20;
    localparam int N_PASS      = 40;
    localparam int N_PRE       = 16;
    localparam int N_MEM       = 200;
    localparam int N_CSR       = 60;
    localparam int N_FLUSH     = 150;
    localparam int N_STALL     = 200;
    localparam int N_DRAIN     = 8;
    localparam int RUN_CYCLES  = 11 + N_PASS + N_PRE + N_MEM + N_CSR + N_FLUSH + N_STALL + N_DRAIN;
    localparam int M_PASS      = 0;
    localparam int M_MEM       = 1;
    localparam int M_CSR       = 2;
    localparam int M_FLUSH     = 3;
    localparam int M_STALL     = 4;

    logic                     CLK, reset, flush, mem_wait;
    logic [REG_BITS-1:0]      exec_reg_w_rd, exec_mem_r_rd, reg_w_rd, load_w_rd;
    logic [XLEN-1:0]          exec_reg_w_data, exec_csr_w_data, exec_mem_r_addr;
    logic [XLEN-1:0]          exec_mem_w_addr, exec_mem_w_data, exec_jmp_pc;
    logic                     exec_csr_w_valid, exec_mem_r_valid, exec_mem_r_signed;
    logic                     exec_mem_w_valid, exec_jmp_do, jmp_do, load_w_valid;
    logic [CSR_ADDR_BITS-1:0] exec_csr_w_addr, csr_r_addr;
    logic [LANES-1:0]         exec_mem_r_strb, exec_mem_w_strb;
    logic [XLEN-1:0]          reg_w_data, jmp_pc, load_w_data, csr_r_data;

    // reference model state
    logic [XLEN-1:0]          mem_model [DEPTH_WORDS];
    logic [XLEN-1:0]          csr_model [4];
    logic [REG_BITS-1:0]      st_reg_rd, st_r_rd, bank_rd, wb_rd;
    logic [XLEN-1:0]          st_reg_data, st_jmp_pc, st_csr_data, st_r_addr;
    logic [XLEN-1:0]          st_w_addr, st_w_data, bank_data, wb_data;
    logic                     st_jmp_do, st_csr_valid, st_r_valid, st_r_signed, st_w_valid;
    logic                     bank_valid, wb_valid;
    logic [CSR_ADDR_BITS-1:0] st_csr_addr;
    logic [LANES-1:0]         st_r_strb, st_w_strb;
    logic [LANES-1:0]         legal_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                                4'b0011, 4'b1100, 4'b1111};
    int                       errors = 0, checks = 0, tests = 0, failed = 0;
    int                       stall_left = 0, mark;

    mem_stage_top #(.DEPTH_WORDS(DEPTH_WORDS)) mem_stage_top_inst (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic int lowest_lane(input logic [LANES-1:0] strb);
        for (int i = 0; i < LANES; i++) begin
            if (strb[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // store data arrives low-aligned
    function automatic logic [XLEN-1:0] store_merge(input logic [XLEN-1:0] old,
                                                    input logic [LANES-1:0] strb,
                                                    input logic [XLEN-1:0] data);
        logic [XLEN-1:0] w;
        int lo;
        w  = old;
        lo = lowest_lane(strb);
        for (int j = 0; j < LANES; j++) begin
            if (strb[j]) begin
                w[j*8 +: 8] = data[(j-lo)*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
                                                   input logic [LANES-1:0] strb,
                                                   input logic sgn);
        logic [XLEN-1:0] v;
        v = word >> (8 * lowest_lane(strb));
        case ($countones(strb))
            1: v = {{24{sgn & v[7]}}, v[7:0]};
            2: v = {{16{sgn & v[15]}}, v[15:0]};
            default: ;
        endcase
        return v;
    endfunction

    function automatic int csr_slot(input logic [CSR_ADDR_BITS-1:0] addr);
        case (addr)
            CSR_MSCRATCH: return 0;
            CSR_MTVEC:    return 1;
            CSR_MEPC:     return 2;
            CSR_MCAUSE:   return 3;
            default:      return -1;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] read_csr(input logic [CSR_ADDR_BITS-1:0] addr);
        int slot;
        slot = csr_slot(addr);
        return (slot < 0) ? '0 : csr_model[slot];
    endfunction

    function automatic logic [CSR_ADDR_BITS-1:0] pick_csr_addr();
        case ($urandom % 5)
            0: return CSR_MSCRATCH;
            1: return CSR_MTVEC;
            2: return CSR_MEPC;
            3: return CSR_MCAUSE;
            default: return CSR_ADDR_BITS'($urandom);
        endcase
    endfunction

    // one model step per rising edge with the oldest stage first
    always @(posedge CLK) begin
        if (reset) begin
            wb_valid = 1'b0;
        end else begin
            wb_valid = bank_valid && !mem_wait;
            if (wb_valid) begin
                wb_rd   = bank_rd;
                wb_data = bank_data;
            end
        end
        if (reset) begin
            bank_valid = 1'b0;
        end else if (!mem_wait) begin
            bank_valid = st_r_valid && !st_w_valid;
            if (st_w_valid) begin
                mem_model[st_w_addr[IDX_BITS+1:2]] =
                    store_merge(mem_model[st_w_addr[IDX_BITS+1:2]], st_w_strb, st_w_data);
            end
            if (bank_valid) begin
                bank_rd   = st_r_rd;
                bank_data = load_value(mem_model[st_r_addr[IDX_BITS+1:2]], st_r_strb, st_r_signed);
            end
        end
        if (reset) begin
            csr_model = '{default: '0};
        end else if (st_csr_valid && csr_slot(st_csr_addr) >= 0) begin
            csr_model[csr_slot(st_csr_addr)] = st_csr_data;
        end
        if (reset || flush) begin
            st_reg_rd    = '0;
            st_reg_data  = '0;
            st_jmp_do    = 1'b0;
            st_jmp_pc    = '0;
            st_csr_valid = 1'b0;
            st_r_valid   = 1'b0;
            st_w_valid   = 1'b0;
        end else if (!mem_wait) begin
            st_reg_rd    = exec_reg_w_rd;
            st_reg_data  = exec_reg_w_data;
            st_jmp_do    = exec_jmp_do;
            st_jmp_pc    = exec_jmp_pc;
            st_csr_valid = exec_csr_w_valid;
            st_csr_addr  = exec_csr_w_addr;
            st_csr_data  = exec_csr_w_data;
            st_r_valid   = exec_mem_r_valid;
            st_r_rd      = exec_mem_r_rd;
            st_r_addr    = exec_mem_r_addr;
            st_r_strb    = exec_mem_r_strb;
            st_r_signed  = exec_mem_r_signed;
            st_w_valid   = exec_mem_w_valid;
            st_w_addr    = exec_mem_w_addr;
            st_w_strb    = exec_mem_w_strb;
            st_w_data    = exec_mem_w_data;
        end
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: got %h, expected %h at %0t ns", name, actual, expected, $time);
        end
    endtask

    task automatic compare_outputs();
        check("reg_w_rd", 32'(reg_w_rd), 32'(st_reg_rd));
        check("reg_w_data", reg_w_data, st_reg_data);
        check("jmp_do", 32'(jmp_do), 32'(st_jmp_do));
        check("jmp_pc", jmp_pc, st_jmp_pc);
        check("load_w_valid", 32'(load_w_valid), 32'(wb_valid));
        if (wb_valid) begin
            check("load_w_rd", 32'(load_w_rd), 32'(wb_rd));
            check("load_w_data", load_w_data, wb_data);
        end
        check("csr_r_data", csr_r_data, read_csr(csr_r_addr));
    endtask

    // op 0 idle, 1 store, 2 load, 3 csr write
    task automatic drive_random(input int mode);
        int op;
        logic [LANES-1:0] strb;
        logic [XLEN-1:0] addr;
        op   = int'($urandom % 4);
        strb = legal_strb[int'($urandom % 7)];
        addr = {22'($urandom), 4'd0, 4'($urandom), 2'(lowest_lane(strb))};
        if (mode == M_PASS) begin
            op = 0;
        end else if (mode == M_MEM && op == 3) begin
            op = 2;
        end else if (mode == M_CSR && (op == 1 || op == 2)) begin
            op = 3;
        end
        exec_reg_w_rd     = REG_BITS'($urandom);
        exec_reg_w_data   = $urandom;
        exec_jmp_do       = ($urandom % 4 == 0);
        exec_jmp_pc       = $urandom;
        exec_mem_w_valid  = (op == 1);
        exec_mem_w_addr   = addr;
        exec_mem_w_strb   = strb;
        exec_mem_w_data   = $urandom;
        exec_mem_r_valid  = (op == 2);
        exec_mem_r_rd     = REG_BITS'($urandom);
        exec_mem_r_addr   = addr;
        exec_mem_r_strb   = strb;
        exec_mem_r_signed = 1'($urandom);
        exec_csr_w_valid  = (op == 3);
        exec_csr_w_addr   = pick_csr_addr();
        exec_csr_w_data   = $urandom;
        csr_r_addr        = pick_csr_addr();
        flush             = (mode == M_FLUSH) && ($urandom % 4 == 0);
    endtask

    task automatic run_cycles(input int n, input int mode);
        for (int c = 0; c < n; c++) begin
            @(negedge CLK);
            compare_outputs();
            flush = 1'b0;
            if (mode == M_STALL) begin
                if (stall_left > 0) begin
                    stall_left--;
                end else if ($urandom % 4 == 0) begin
                    stall_left = 1 + int'($urandom % 4);
                end
                mem_wait = (stall_left > 0);
            end else begin
                mem_wait = 1'b0;
            end
            // execute holds its request while stalled
            if (!mem_wait) begin
                drive_random(mode);
            end
        end
    endtask

    // full-word stores so every word used later holds known data
    task automatic preload_words();
        for (int w = 0; w < N_PRE; w++) begin
            @(negedge CLK);
            compare_outputs();
            mem_wait = 1'b0;
            drive_random(M_PASS);
            exec_mem_w_valid = 1'b1;
            exec_mem_w_addr  = {22'($urandom), 4'd0, 4'(w), 2'd0};
            exec_mem_w_strb  = 4'b1111;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        void'($urandom(16));
        CLK   = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        mem_wait = 1'b0;
        drive_random(M_PASS);
        exec_jmp_do = 1'b1;
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        mark  = errors;
        check("jmp_do", 32'(jmp_do), 32'd0);
        check("load_w_valid", 32'(load_w_valid), 32'd0);
        run_cycles(N_PASS, M_PASS);
        finish_test("reg write and jump passthrough", mark);
        mark = errors;
        preload_words();
        run_cycles(N_MEM, M_MEM);
        finish_test("store then load", mark);
        mark = errors;
        run_cycles(N_CSR, M_CSR);
        finish_test("csr writes", mark);
        mark = errors;
        run_cycles(N_FLUSH, M_FLUSH);
        finish_test("flush", mark);
        mark = errors;
        run_cycles(N_STALL, M_STALL);
        run_cycles(N_DRAIN, M_PASS);
        errors += mem_stage_top_inst.asserts_inst.fail_count;
        finish_test("mem_wait stall", mark);
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((RUN_CYCLES + 100) * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* flist.f */
hw/core_mem_pkg.sv
hw/cushion.sv
hw/store_align.sv
hw/data_bank.sv
hw/load_align.sv
hw/csr_file.sv
hw/mem_stage_top.sv
tests/mem_stage_asserts.sv
tests/mem_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_stage_tb -f flist.f

out=$(./obj_dir/Vmem_stage_tb)
echo "$out"
echo "$out" | grep -q "^RESULT: PASS$"
